// ==== tb.f ====
+incdir+logic
logic/soc_pkg.sv
logic/mem_decoder.sv
logic/bram.sv
logic/print.sv
logic/clint.sv
logic/clic.sv
logic/soc.sv
verification/tb_clock.sv
verification/soc_checker.sv
verification/tb_soc.sv

// ==== verification/tb_soc.sv ====
`include "soc_params.svh"

module tb_soc;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS   = 32;
  localparam int CLK_PERIOD  = 4;
  localparam int DRIVE_DELAY = 1;
  localparam int READY_LIMIT = 8;

  localparam logic [1:0] K_WR   = 2'd0;
  localparam logic [1:0] K_RD   = 2'd1;
  localparam logic [1:0] K_IRQ  = 2'd2;
  localparam logic [1:0] K_TIME = 2'd3;

  typedef struct packed {
    logic [8*16-1:0]          name;
    logic [1:0]               kind;
    logic [31:0]              addr;
    logic [31:0]              wdata;
    logic [3:0]               wstrb;
    logic [`CLIC_NUM_IRQ-1:0] irq;
    logic [3:0]               chk;
    logic [31:0]              exp_rdata;
    logic [7:0]               exp_tx;
    logic                     exp_msip;
    logic                     exp_mtip;
    logic                     exp_meip;
    logic [11:0]              exp_meid;
  } entry_t;

  logic                     clk;
  logic                     arst_n;
  soc_pkg::mem_req_t        req;
  soc_pkg::mem_rsp_t        rsp;
  logic [`CLIC_NUM_IRQ-1:0] irq;
  logic                     tx_valid;
  logic [7:0]               tx_data;
  logic                     msip;
  logic                     mtip;
  logic                     meip;
  logic [11:0]              meid;
  logic [63:0]              mtime;
  logic                     go;
  int                       cur_idx;
  entry_t                   cur;
  int                       errors;
  int                       tests_run;

  entry_t      tests [NUM_TESTS];
  int          n_built;
  logic [31:0] ref_mem [0:`BRAM_WORDS-1];
  logic [31:0] rnd [0:3];

  tb_clock clock0 (
    .clk    (clk),
    .arst_n (arst_n)
  );

  soc dut0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (req),
    .rsp      (rsp),
    .irq      (irq),
    .tx_valid (tx_valid),
    .tx_data  (tx_data),
    .msip     (msip),
    .mtip     (mtip),
    .meip     (meip),
    .meid     (meid),
    .mtime    (mtime)
  );

  soc_checker checker0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .rsp       (rsp),
    .tx_valid  (tx_valid),
    .tx_data   (tx_data),
    .msip      (msip),
    .mtip      (mtip),
    .meip      (meip),
    .meid      (meid),
    .mtime     (mtime),
    .go        (go),
    .idx       (cur_idx),
    .name      (cur.name),
    .kind      (cur.kind),
    .chk       (cur.chk),
    .exp_rdata (cur.exp_rdata),
    .exp_tx    (cur.exp_tx),
    .exp_msip  (cur.exp_msip),
    .exp_mtip  (cur.exp_mtip),
    .exp_meip  (cur.exp_meip),
    .exp_meid  (cur.exp_meid),
    .errors    (errors),
    .tests_run (tests_run)
  );

  // ====================
  // table building
  // ====================
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  task automatic add(input logic [8*16-1:0] name, input logic [1:0] kind,
                     input logic [31:0] addr, input logic [31:0] wdata,
                     input logic [3:0] wstrb);
    entry_t e;
    e       = '0;
    e.name  = name;
    e.kind  = kind;
    e.addr  = addr;
    e.wdata = wdata;
    e.wstrb = wstrb;
    tests[n_built] = e;
    n_built++;
  endtask

  // reference copy of the ram, only for mapped bram addresses
  task automatic wr(input logic [8*16-1:0] name, input logic [31:0] addr,
                    input logic [31:0] data, input logic [3:0] strb);
    add(name, K_WR, addr, data, strb);
    if (addr - `BRAM_BASE < `BRAM_WORDS * 4) begin
      ref_mem[(addr - `BRAM_BASE) >> 2] = merge_lanes(ref_mem[(addr - `BRAM_BASE) >> 2],
                                                      data, strb);
    end
  endtask

  task automatic rd(input logic [8*16-1:0] name, input logic [31:0] addr,
                    input logic [31:0] expected);
    add(name, K_RD, addr, 32'd0, 4'b0000);
    tests[n_built-1].chk[0]    = 1'b1;
    tests[n_built-1].exp_rdata = expected;
  endtask

  task automatic rd_bram(input logic [8*16-1:0] name, input logic [31:0] addr);
    rd(name, addr, ref_mem[(addr - `BRAM_BASE) >> 2]);
  endtask

  task automatic set_irq(input logic [8*16-1:0] name, input logic [`CLIC_NUM_IRQ-1:0] value);
    add(name, K_IRQ, 32'd0, 32'd0, 4'b0000);
    tests[n_built-1].irq = value;
  endtask

  task automatic expect_tx(input logic [7:0] data);
    tests[n_built-1].chk[1] = 1'b1;
    tests[n_built-1].exp_tx = data;
  endtask

  task automatic expect_timer(input logic msip_v, input logic mtip_v);
    tests[n_built-1].chk[2]   = 1'b1;
    tests[n_built-1].exp_msip = msip_v;
    tests[n_built-1].exp_mtip = mtip_v;
  endtask

  task automatic expect_irq(input logic meip_v, input logic [11:0] meid_v);
    tests[n_built-1].chk[3]   = 1'b1;
    tests[n_built-1].exp_meip = meip_v;
    tests[n_built-1].exp_meid = meid_v;
  endtask

  task automatic build_table();
    n_built = 0;
    for (int i = 0; i < 4; i++) begin
      rnd[i] = $urandom;
    end
    wr("bram wr 0", `BRAM_BASE + 32'h000, rnd[0], 4'b1111);
    wr("bram wr 1", `BRAM_BASE + 32'h004, rnd[1], 4'b1111);
    wr("bram wr last", `BRAM_BASE + 32'h3FC, rnd[2], 4'b1111);
    rd_bram("bram rd 0", `BRAM_BASE + 32'h000);
    rd_bram("bram rd 1", `BRAM_BASE + 32'h004);
    rd_bram("bram rd last", `BRAM_BASE + 32'h3FC);
    wr("bram strb 0101", `BRAM_BASE + 32'h004, rnd[3], 4'b0101);
    rd_bram("bram rd merge 1", `BRAM_BASE + 32'h004);
    wr("bram strb 1000", `BRAM_BASE + 32'h000, rnd[3], 4'b1000);
    rd_bram("bram rd merge 0", `BRAM_BASE + 32'h000);
    wr("print A", `PRINT_BASE, 32'h0000_0041, 4'b1111);
    expect_tx(8'h41);
    wr("print low byte", `PRINT_BASE, 32'h1234_5642, 4'b1111);
    expect_tx(8'h42);
    rd("print count", `PRINT_BASE, 32'd2);
    wr("msip set", `CLINT_BASE + `CLINT_MSIP_OFS, 32'd1, 4'b1111);
    expect_timer(1'b1, 1'b0);
    wr("msip bit 0 only", `CLINT_BASE + `CLINT_MSIP_OFS, 32'd2, 4'b1111);
    expect_timer(1'b0, 1'b0);
    wr("mtimecmp lo 0", `CLINT_BASE + `CLINT_MTIMECMP_OFS, 32'd0, 4'b1111);
    expect_timer(1'b0, 1'b0);
    wr("mtimecmp hi 0", `CLINT_BASE + `CLINT_MTIMECMP_OFS + 32'd4, 32'd0, 4'b1111);
    expect_timer(1'b0, 1'b1);
    wr("mtimecmp hi 1s", `CLINT_BASE + `CLINT_MTIMECMP_OFS + 32'd4, '1, 4'b1111);
    expect_timer(1'b0, 1'b0);
    wr("mtimecmp lo 1s", `CLINT_BASE + `CLINT_MTIMECMP_OFS, '1, 4'b1111);
    expect_timer(1'b0, 1'b0);
    add("mtime rd a", K_TIME, `CLINT_BASE + `CLINT_MTIME_OFS, 32'd0, 4'b0000);
    add("mtime rd b", K_TIME, `CLINT_BASE + `CLINT_MTIME_OFS, 32'd0, 4'b0000);
    // lines 2 and 5 up, nothing enabled yet
    set_irq("irq 2 and 5", 8'h24);
    expect_irq(1'b0, 12'd0);
    wr("clic enable", `CLIC_BASE + `CLIC_ENABLE_OFS, 32'h24, 4'b1111);
    expect_irq(1'b1, 12'd2);
    rd("claim 2", `CLIC_BASE + `CLIC_CLAIM_OFS, 32'd2);
    expect_irq(1'b1, 12'd2);
    set_irq("irq 2 drops", 8'h20);
    expect_irq(1'b1, 12'd2);
    wr("clear pending 2", `CLIC_BASE + `CLIC_PENDING_OFS, 32'h04, 4'b1111);
    expect_irq(1'b1, 12'd5);
    rd("claim 5", `CLIC_BASE + `CLIC_CLAIM_OFS, 32'd5);
    expect_irq(1'b1, 12'd5);
    set_irq("irq 5 drops", 8'h00);
    expect_irq(1'b1, 12'd5);
    wr("clear pending 5", `CLIC_BASE + `CLIC_PENDING_OFS, 32'h20, 4'b1111);
    expect_irq(1'b0, 12'd0);
    // just past the ram, would alias word 0 if decoded as bram
    wr("unmapped wr", 32'h0000_0400, rnd[2], 4'b1111);
    rd("unmapped rd", 32'h0000_0400, 32'd0);
    rd_bram("bram rd after", `BRAM_BASE + 32'h000);
  endtask

  // ====================
  // driving
  // ====================
  task automatic apply(input int i);
    int   waited;
    logic got;
    cur     = tests[i];
    cur_idx = i;
    go      = 1'b1;
    if (cur.kind == K_IRQ) begin
      irq = cur.irq;
    end else begin
      req.valid = 1'b1;
      req.instr = 1'b0;
      req.addr  = cur.addr;
      req.wdata = cur.wdata;
      req.wstrb = cur.wstrb;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    go = 1'b0;
    if (cur.kind == K_IRQ) begin
      @(posedge clk);
    end else begin
      waited = 0;
      got    = 1'b0;
      while (!got && waited < READY_LIMIT) begin
        @(posedge clk);
        got = rsp.ready;
        waited++;
      end
    end
    #DRIVE_DELAY;
    req = '0;
    // idle cycle between tests
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  initial begin
    req     = '0;
    irq     = '0;
    go      = 1'b0;
    cur     = '0;
    cur_idx = 0;
    void'($urandom(26654));
    build_table();
    @(posedge arst_n);
    @(posedge clk);
    #DRIVE_DELAY;
    for (int i = 0; i < n_built; i++) begin
      apply(i);
    end
    repeat (2) @(posedge clk);
    $display("summary: %0d of %0d tests run, %0d errors", tests_run, n_built, errors);
    if (tests_run != n_built) begin
      $display("not every test reached the checker");
    end
    if (errors == 0 && tests_run == n_built) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((NUM_TESTS * 10 + 40) * CLK_PERIOD);
    $display("timeout: run still busy after %0d cycles", NUM_TESTS * 10 + 40);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== verification/soc_checker.sv ====
module soc_checker (
  input  logic              clk,
  input  logic              arst_n,
  input  soc_pkg::mem_rsp_t rsp,
  input  logic              tx_valid,
  input  logic [7:0]        tx_data,
  input  logic              msip,
  input  logic              mtip,
  input  logic              meip,
  input  logic [11:0]       meid,
  input  logic [63:0]       mtime,
  input  logic              go,
  input  int                idx,
  input  logic [8*16-1:0]   name,
  input  logic [1:0]        kind,
  input  logic [3:0]        chk,
  input  logic [31:0]       exp_rdata,
  input  logic [7:0]        exp_tx,
  input  logic              exp_msip,
  input  logic              exp_mtip,
  input  logic              exp_meip,
  input  logic [11:0]       exp_meid,
  output int                errors,
  output int                tests_run
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] K_IRQ  = 2'd2;
  localparam logic [1:0] K_TIME = 2'd3;
  localparam int CHK_RDATA = 0;
  localparam int CHK_TX    = 1;
  localparam int CHK_TIMER = 2;
  localparam int CHK_IRQ   = 3;
  localparam int READY_LIMIT = 8;

  int          edges;
  int          mismatches;
  logic        have_prev;
  logic [31:0] prev_time;
  int          prev_edge;
  longint      run_edges;

  initial begin
    errors    = 0;
    tests_run = 0;
    edges     = 0;
    have_prev = 1'b0;
    run_edges = 0;
  end

  task automatic compare_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("FAIL %0t ns %s: expected 0x%08h, actual 0x%08h", $time, sig, expected, actual);
      mismatches++;
    end
  endtask

  task automatic compare_outputs();
    if (chk[CHK_RDATA]) begin
      compare_value("rdata", exp_rdata, rsp.rdata);
    end
    if (chk[CHK_TX]) begin
      compare_value("tx_valid", 32'd1, 32'(tx_valid));
      compare_value("tx_data", 32'(exp_tx), 32'(tx_data));
    end
    if (chk[CHK_TIMER]) begin
      compare_value("msip", 32'(exp_msip), 32'(msip));
      compare_value("mtip", 32'(exp_mtip), 32'(mtip));
    end
    if (chk[CHK_IRQ]) begin
      compare_value("meip", 32'(exp_meip), 32'(meip));
      compare_value("meid", 32'(exp_meid), 32'(meid));
    end
  endtask

  // two reads in a row, the second against the first
  task automatic check_mtime();
    logic [31:0] delta;
    if (!have_prev) begin
      prev_time = rsp.rdata;
      prev_edge = edges;
      have_prev = 1'b1;
    end else begin
      delta = rsp.rdata - prev_time;
      if (rsp.rdata < prev_time) begin
        $display("FAIL %0t ns mtime: expected >= 0x%08h, actual 0x%08h",
                 $time, prev_time, rsp.rdata);
        mismatches++;
      end else if (delta < 32'(edges - prev_edge)) begin
        $display("FAIL %0t ns mtime_delta: expected >= %0d, actual %0d",
                 $time, edges - prev_edge, delta);
        mismatches++;
      end
      have_prev = 1'b0;
    end
  endtask

  // ====================
  // one test
  // ====================
  task automatic run_test();
    int             waited;
    int             t_idx;
    logic [1:0]     t_kind;
    logic [8*16-1:0] t_name;
    mismatches = 0;
    waited     = 0;
    t_idx      = idx;
    t_kind     = kind;
    t_name     = name;
    @(posedge clk);
    edges++;
    if (t_kind != K_IRQ) begin
      waited = 1;
      while (!rsp.ready && waited < READY_LIMIT) begin
        @(posedge clk);
        edges++;
        waited++;
      end
    end
    if (t_kind != K_IRQ && !rsp.ready) begin
      $display("test %0d: no ready response within %0d cycles of the request",
               t_idx, READY_LIMIT);
      mismatches++;
    end else begin
      if (t_kind != K_IRQ && waited != 1) begin
        $display("test %0d: ready came %0d cycles after the request instead of 1",
                 t_idx, waited);
        mismatches++;
      end
      compare_outputs();
      if (t_kind == K_TIME) begin
        check_mtime();
      end
    end
    errors += mismatches;
    tests_run++;
    $display("test %2d %s: %s", t_idx, t_name, (mismatches == 0) ? "ok" : "failed");
  endtask

  always begin
    @(posedge clk);
    edges++;
    if (go) begin
      run_test();
    end
  end

  // ====================
  // free-running mtime
  // ====================
  // counts edges since reset release, the table never writes it
  always @(posedge clk) begin
    if (!arst_n) begin
      run_edges = 0;
    end else begin
      if (mtime !== 64'(run_edges)) begin
        $display("FAIL %0t ns mtime: expected 0x%016h, actual 0x%016h",
                 $time, 64'(run_edges), mtime);
        errors++;
      end
      run_edges++;
    end
  end

endmodule

// ==== verification/tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic arst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

// ==== logic/soc.sv ====
`include "soc_params.svh"

module soc (
  input  logic                     clk,
  input  logic                     arst_n,
  input  soc_pkg::mem_req_t         req,
  output soc_pkg::mem_rsp_t         rsp,
  input  logic [`CLIC_NUM_IRQ-1:0] irq,
  output logic                     tx_valid,
  output logic [7:0]               tx_data,
  output logic                     msip,
  output logic                     mtip,
  output logic                     meip,
  output logic [11:0]              meid,
  output logic [63:0]              mtime
);

  soc_pkg::mem_req_t bram_req;
  soc_pkg::mem_req_t print_req;
  soc_pkg::mem_req_t clint_req;
  soc_pkg::mem_req_t clic_req;
  soc_pkg::mem_rsp_t bram_rsp;
  soc_pkg::mem_rsp_t print_rsp;
  soc_pkg::mem_rsp_t clint_rsp;
  soc_pkg::mem_rsp_t clic_rsp;

  // ====================
  // address decode
  // ====================
  mem_decoder decoder0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .req       (req),
    .rsp       (rsp),
    .bram_req  (bram_req),
    .print_req (print_req),
    .clint_req (clint_req),
    .clic_req  (clic_req),
    .bram_rsp  (bram_rsp),
    .print_rsp (print_rsp),
    .clint_rsp (clint_rsp),
    .clic_rsp  (clic_rsp)
  );

  // ====================
  // targets
  // ====================
  bram bram0 (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (bram_req),
    .rsp    (bram_rsp)
  );

  print print0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .req      (print_req),
    .rsp      (print_rsp),
    .tx_valid (tx_valid),
    .tx_data  (tx_data)
  );

  clint clint0 (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (clint_req),
    .rsp    (clint_rsp),
    .msip   (msip),
    .mtip   (mtip),
    .mtime  (mtime)
  );

  clic clic0 (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (clic_req),
    .rsp    (clic_rsp),
    .irq    (irq),
    .meip   (meip),
    .meid   (meid)
  );

endmodule

// ==== logic/clic.sv ====
`include "soc_params.svh"

module clic (
  input  logic                     clk,
  input  logic                     arst_n,
  input  soc_pkg::mem_req_t         req,
  output soc_pkg::mem_rsp_t         rsp,
  input  logic [`CLIC_NUM_IRQ-1:0] irq,
  output logic                     meip,
  output logic [11:0]              meid
);

  localparam int N   = `CLIC_NUM_IRQ;
  localparam int IDW = $clog2(N);

  logic          access;
  logic          wr;
  logic [31:0]   word_addr;
  logic [31:0]   clr_word;
  logic [31:0]   en_word;
  logic          ready_q;
  logic [31:0]   rdata_q;
  logic [N-1:0]  pending_q;
  logic [N-1:0]  enable_q;
  logic [N-1:0]  active;
  logic [11:0]   meid_c;

  assign access    = req.valid && !ready_q;
  assign wr        = access && (req.wstrb != 4'b0000);
  assign word_addr = {req.addr[31:2], 2'b00};

  // write data seen through the byte strobes
  assign clr_word = soc_pkg::wstrb_merge(32'd0, req.wdata, req.wstrb);
  assign en_word  = soc_pkg::wstrb_merge(32'(enable_q), req.wdata, req.wstrb);

  // ====================
  // pending and enable
  // ====================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q   <= 1'b0;
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      ready_q <= access;
      // a line still high wins over the clear
      if (wr && word_addr == `CLIC_PENDING_OFS) begin
        pending_q <= (pending_q & ~clr_word[N-1:0]) | irq;
      end else begin
        pending_q <= pending_q | irq;
      end
      if (wr && word_addr == `CLIC_ENABLE_OFS) begin
        enable_q <= en_word[N-1:0];
      end
    end
  end

  // lowest active id
  assign active = pending_q & enable_q;

  always_comb begin
    meid_c = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (active[i]) begin
        meid_c = 12'(i);
      end
    end
  end

  assign meip = |active;
  assign meid = meid_c;

  always_ff @(posedge clk) begin
    if (access) begin
      if (word_addr == `CLIC_PENDING_OFS) begin
        rdata_q <= 32'(pending_q);
      end else if (word_addr == `CLIC_ENABLE_OFS) begin
        rdata_q <= 32'(enable_q);
      end else if (word_addr == `CLIC_CLAIM_OFS) begin
        rdata_q <= {20'b0, meid_c};
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

  a_claim_pending: assert property (@(posedge clk) disable iff (!arst_n)
    meip |-> pending_q[meid[IDW-1:0]] && enable_q[meid[IDW-1:0]]);

endmodule

// ==== logic/clint.sv ====
`include "soc_params.svh"

module clint (
  input  logic             clk,
  input  logic             arst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic             msip,
  output logic             mtip,
  output logic [63:0]      mtime
);

  logic        access;
  logic        wr;
  logic [31:0] word_addr;
  logic        hit_msip;
  logic        hit_cmp_lo;
  logic        hit_cmp_hi;
  logic        hit_time_lo;
  logic        hit_time_hi;
  logic [31:0] msip_word;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        msip_q;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtime_q;

  assign access    = req.valid && !ready_q;
  assign wr        = access && (req.wstrb != 4'b0000);
  assign word_addr = {req.addr[31:2], 2'b00};

  assign hit_msip    = word_addr == `CLINT_MSIP_OFS;
  assign hit_cmp_lo  = word_addr == `CLINT_MTIMECMP_OFS;
  assign hit_cmp_hi  = word_addr == `CLINT_MTIMECMP_OFS + 32'd4;
  assign hit_time_lo = word_addr == `CLINT_MTIME_OFS;
  assign hit_time_hi = word_addr == `CLINT_MTIME_OFS + 32'd4;

  assign msip_word = soc_pkg::wstrb_merge({31'b0, msip_q}, req.wdata, req.wstrb);

  // ====================
  // registers
  // ====================
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q    <= 1'b0;
      msip_q     <= 1'b0;
      mtimecmp_q <= '1;
      mtime_q    <= '0;
    end else begin
      ready_q <= access;
      if (wr && hit_msip) begin
        msip_q <= msip_word[0];
      end
      if (wr && hit_cmp_lo) begin
        mtimecmp_q[31:0] <= soc_pkg::wstrb_merge(mtimecmp_q[31:0], req.wdata, req.wstrb);
      end
      if (wr && hit_cmp_hi) begin
        mtimecmp_q[63:32] <= soc_pkg::wstrb_merge(mtimecmp_q[63:32], req.wdata, req.wstrb);
      end
      // counter holds in the cycle it is written
      if (wr && hit_time_lo) begin
        mtime_q[31:0] <= soc_pkg::wstrb_merge(mtime_q[31:0], req.wdata, req.wstrb);
      end else if (wr && hit_time_hi) begin
        mtime_q[63:32] <= soc_pkg::wstrb_merge(mtime_q[63:32], req.wdata, req.wstrb);
      end else begin
        mtime_q <= mtime_q + 64'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (hit_msip) begin
        rdata_q <= {31'b0, msip_q};
      end else if (hit_cmp_lo) begin
        rdata_q <= mtimecmp_q[31:0];
      end else if (hit_cmp_hi) begin
        rdata_q <= mtimecmp_q[63:32];
      end else if (hit_time_lo) begin
        rdata_q <= mtime_q[31:0];
      end else if (hit_time_hi) begin
        rdata_q <= mtime_q[63:32];
      end else begin
        rdata_q <= '0;
      end
    end
  end

  assign msip  = msip_q;
  assign mtip  = mtime_q >= mtimecmp_q;
  assign mtime = mtime_q;

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

  a_ready_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    ready_q |=> !ready_q);

endmodule

// ==== logic/print.sv ====
module print (
  input  logic             clk,
  input  logic             arst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output logic             tx_valid,
  output logic [7:0]       tx_data
);

  logic        access;
  logic        at_zero;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic [31:0] count;

  assign access  = req.valid && !ready_q;
  assign at_zero = req.addr[31:2] == 30'd0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q  <= 1'b0;
      tx_valid <= 1'b0;
      count    <= '0;
    end else begin
      ready_q  <= access;
      tx_valid <= access && at_zero && (req.wstrb != 4'b0000);
      if (access && at_zero && (req.wstrb != 4'b0000)) begin
        count <= count + 32'd1;
      end
    end
  end

  // character byte and read data
  always_ff @(posedge clk) begin
    if (access) begin
      tx_data <= req.wdata[7:0];
      rdata_q <= at_zero ? count : 32'd0;
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

// ==== logic/bram.sv ====
`include "soc_params.svh"

module bram (
  input  logic             clk,
  input  logic             arst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  localparam int AW = $clog2(`BRAM_WORDS);

  logic [31:0]   mem [0:`BRAM_WORDS-1];
  logic [AW-1:0] idx;
  logic          access;
  logic          ready_q;
  logic [31:0]   rdata_q;

  // word index, byte offset dropped
  assign idx    = req.addr[AW+1:2];
  assign access = req.valid && !ready_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= access;
    end
  end

  // ====================
  // storage
  // ====================
  // instruction and data fetches are served alike
  always_ff @(posedge clk) begin
    if (access) begin
      if (req.wstrb != 4'b0000) begin
        mem[idx] <= soc_pkg::wstrb_merge(mem[idx], req.wdata, req.wstrb);
      end
      rdata_q <= mem[idx];
    end
  end

  assign rsp.ready = ready_q;
  assign rsp.rdata = rdata_q;

endmodule

// ==== logic/mem_decoder.sv ====
`include "soc_params.svh"

module mem_decoder (
  input  logic             clk,
  input  logic             arst_n,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp,
  output soc_pkg::mem_req_t bram_req,
  output soc_pkg::mem_req_t print_req,
  output soc_pkg::mem_req_t clint_req,
  output soc_pkg::mem_req_t clic_req,
  input  soc_pkg::mem_rsp_t bram_rsp,
  input  soc_pkg::mem_rsp_t print_rsp,
  input  soc_pkg::mem_rsp_t clint_rsp,
  input  soc_pkg::mem_rsp_t clic_rsp
);

  logic              sel_bram;
  logic              sel_print;
  logic              sel_clint;
  logic              sel_clic;
  logic [31:0]       base;
  soc_pkg::mem_req_t fwd;
  logic              unmapped_ready;

  // wraps below base, so one compare covers both bounds
  function automatic logic in_range(input logic [31:0] addr, input logic [31:0] lo,
                                    input logic [31:0] size);
    return (addr - lo) < size;
  endfunction

  // ====================
  // target select
  // ====================
  always_comb begin
    sel_bram  = 1'b0;
    sel_print = 1'b0;
    sel_clint = 1'b0;
    sel_clic  = 1'b0;
    base      = '0;
    if (in_range(req.addr, `CLINT_BASE, `CLINT_SIZE)) begin
      sel_clint = 1'b1;
      base      = `CLINT_BASE;
    end else if (in_range(req.addr, `CLIC_BASE, `CLIC_SIZE)) begin
      sel_clic = 1'b1;
      base     = `CLIC_BASE;
    end else if (in_range(req.addr, `PRINT_BASE, `PRINT_SIZE)) begin
      sel_print = 1'b1;
      base      = `PRINT_BASE;
    end else if (in_range(req.addr, `BRAM_BASE, 32'(`BRAM_WORDS * 4))) begin
      sel_bram = 1'b1;
      base     = `BRAM_BASE;
    end
  end

  always_comb begin
    fwd       = req;
    fwd.addr  = req.addr - base;
    fwd.valid = 1'b0;

    bram_req        = fwd;
    bram_req.valid  = req.valid & sel_bram;
    print_req       = fwd;
    print_req.valid = req.valid & sel_print;
    clint_req       = fwd;
    clint_req.valid = req.valid & sel_clint;
    clic_req        = fwd;
    clic_req.valid  = req.valid & sel_clic;
  end

  // no target hit, answer with zero data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      unmapped_ready <= 1'b0;
    end else begin
      unmapped_ready <= req.valid && !(sel_bram | sel_print | sel_clint | sel_clic) &&
                        !unmapped_ready;
    end
  end

  // ====================
  // response mux
  // ====================
  always_comb begin
    rsp = '0;
    if (bram_rsp.ready) begin
      rsp = bram_rsp;
    end else if (print_rsp.ready) begin
      rsp = print_rsp;
    end else if (clint_rsp.ready) begin
      rsp = clint_rsp;
    end else if (clic_rsp.ready) begin
      rsp = clic_rsp;
    end else if (unmapped_ready) begin
      rsp.ready = 1'b1;
    end
  end

  a_one_target: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({bram_req.valid, print_req.valid, clint_req.valid, clic_req.valid}));

  a_one_ready: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0({bram_rsp.ready, print_rsp.ready, clint_rsp.ready, clic_rsp.ready,
              unmapped_ready}));

  // requester holds the request until it sees ready
  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    req.valid && !rsp.ready |=> req.valid && $stable(req));

endmodule

// ==== logic/soc_pkg.sv ====
package soc_pkg;

  // ====================
  // native memory port
  // ====================

  // request side, driven by the core
  // wstrb of zero means a read
  typedef struct packed {
    logic        valid;
    logic        instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  // response side, ready pulses for one cycle
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } mem_rsp_t;

  // ====================
  // helpers
  // ====================

  // byte lanes of new_word replace old_word where strb is set
  function automatic logic [31:0] wstrb_merge(
    input logic [31:0] old_word,
    input logic [31:0] new_word,
    input logic [3:0]  strb
  );
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

endpackage

// ==== logic/soc_params.svh ====
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// ====================
// address map
// ====================
`define BRAM_BASE          (32'h0000_0000)
`define BRAM_WORDS         256

`define PRINT_BASE         (32'h1000_0000)
`define PRINT_SIZE         (32'h0000_1000)

`define CLINT_BASE         (32'h0200_0000)
`define CLINT_SIZE         (32'h0001_0000)

`define CLIC_BASE          (32'h0C00_0000)
`define CLIC_SIZE          (32'h0000_1000)

// ====================
// register offsets
// ====================
// 64-bit registers occupy two words, low word first
`define CLINT_MSIP_OFS     (32'h0000_0000)
`define CLINT_MTIMECMP_OFS (32'h0000_4000)
`define CLINT_MTIME_OFS    (32'h0000_BFF8)

`define CLIC_NUM_IRQ       8
`define CLIC_PENDING_OFS   (32'h0000_0000)
`define CLIC_ENABLE_OFS    (32'h0000_0004)
`define CLIC_CLAIM_OFS     (32'h0000_0008)

`endif
